/* Makefile */
VERILATOR ?= verilator
TOP       ?= decoder_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* alu_shift_control.sv */
`include "decoder_cfg.svh"

module alu_shift_control
    import decoder_pkg::*;
(
    input  isr_dec_t   dec,
    input  phase_t     phase,
    input  psw_t       psw,
    output alu_ctl_t   alu,
    output shift_ctl_t shift
);

    logic any_phase;
    logic xfer_op;
    logic any_branch;
    logic pass_a;

    // every phase except ex1
    assign any_phase = phase.if0 | phase.if1 | phase.ff0 | phase.ff1 |
                       phase.ff2 | phase.tf0 | phase.tf1;

    assign xfer_op = (dec.op == op_mov) | (dec.op == op_jmp) |
                     (dec.op == op_ret) | (dec.op == op_rit);

    assign any_branch = dec.is_branch | dec.is_rbranch;

    // adder path used for address arithmetic and moves
    assign pass_a = any_phase | phase.ex1 | xfer_op | dec.is_alu2 |
                    dec.is_call | any_branch;

    always_comb begin
        alu.als = pass_a | (dec.op == op_clr) | dec.is_logic;
        alu.x   = (phase.ff0 & dec.f_mode_oh[mode_mi]) |
                  (dec.op == op_sub) | (dec.op == op_sbc) | (dec.op == op_cmp);
        alu.y   = pass_a;
        alu.z   = (dec.op == op_or);
        alu.v   = pass_a | (dec.op == op_xor);

        // carry in
        alu.u   = phase.if1 | phase.ff1 | phase.tf1 |
                  (dec.op == op_sub) | (dec.op == op_cmp) |
                  ((dec.op == op_adc) & psw.c) |
                  ((dec.op == op_sbc) & ~psw.c);

        alu.mda = phase.ff2 | dec.is_shift | dec.is_alu2 | dec.is_logic | dec.is_rbranch;
        alu.b0b = phase.ex1 | xfer_op | dec.is_alu2 | dec.is_logic |
                  dec.is_call | any_branch;
        alu.sb0 = phase.ff2;
    end

    always_comb begin
        shift.shs = dec.is_shift;
        shift.a   = (dec.op == op_asl) | (dec.op == op_asr);
        shift.b   = (dec.op == op_rol);
        shift.c   = (dec.op == op_lsl) | (dec.op == op_rol) | (dec.op == op_rlc);
        shift.d   = (dec.op == op_ror);
        shift.e   = (dec.op == op_rlc) | (dec.op == op_rrc);
        shift.r   = (dec.op == op_asr) | (dec.op == op_ror) | (dec.op == op_rrc);
        shift.l   = (dec.op == op_asl) | (dec.op == op_lsl) |
                    (dec.op == op_rol) | (dec.op == op_rlc);
    end

endmodule

/* bus_control.sv */
`include "decoder_cfg.svh"

module bus_control
    import decoder_pkg::*;
(
    input  isr_dec_t dec,
    input  phase_t   phase,
    output bus_ctl_t bus
);

    logic mem_req;
    logic instr_req;
    logic rd_phase;

    // ff1 and tf1 only update the pointer, no memory cycle
    assign mem_req = phase.if0 | phase.if1 | phase.ff0 | phase.ff2 | phase.tf0 |
                     phase.ex1 | dec.is_valid;

    assign instr_req = phase.if0 | phase.if1 | phase.ff0 | phase.ff2 |
                       phase.tf0 | phase.tf1 | dec.is_valid;

    // ex1 is the only write cycle
    assign rd_phase = phase.if0 | phase.if1 | phase.ff0 | phase.ff1 |
                      phase.ff2 | phase.tf0 | phase.tf1;

    always_comb begin
        bus.r_w_n  = rd_phase | dec.is_valid;
        bus.mreq_n = ~mem_req;
        bus.mirq_n = ~instr_req;
        bus.mis    = phase.if1;
        bus.mmd    = phase.if1 | phase.tf1;

        // shifter output drives memory data for results and calls
        bus.smd    = phase.if0 | phase.ff0 | phase.tf0 |
                     dec.is_result | dec.is_call;

        // address from shifter on the first cycle of each fetch
        bus.sma    = phase.if0 | phase.ff0 | phase.tf0;
        bus.mdm    = phase.ex1;
    end

endmodule

/* decoder_assert.sv */
module decoder_assert
    import decoder_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input isr_t     isr,
    input phase_t   phase,
    input psw_t     psw,
    input reg_ctl_t reg_ctl,
    input bus_ctl_t bus
);

    logic br_now;
    logic flag_now;

    // both branch groups have op[5:4] = 11 and op[2] = 0
    assign br_now   = (isr.op[5:4] == 2'b11) && !isr.op[2];
    assign flag_now = psw[2'd3 - isr.op[1:0]];

    idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |=> (bus.mreq_n && bus.mirq_n))
        else $error("memory request active right after reset");

    mis_needs_mmd: assert property (@(posedge clk) disable iff (reset)
        bus.mis |-> (bus.mmd && $past(phase.if1)))
        else $error("mis without mmd or without if1 one cycle earlier");

    branch_needs_flag: assert property (@(posedge clk) disable iff (reset)
        ($rose(reg_ctl.w_sel[7]) && $past(br_now) && ($past(phase) == '0))
        |-> $past(flag_now))
        else $error("pc written by a branch whose flag was clear");

endmodule

bind microcode_decoder decoder_assert u_decoder_assert (.*);

/* decoder_cfg.svh */
`ifndef DECODER_CFG_SVH
`define DECODER_CFG_SVH

// instruction-state register width
`define DEC_ISR_W 16

// execution state (opcode) field
`define DEC_OP_W 6

// addressing mode field, four modes
`define DEC_MODE_W 2

// register number field
`define DEC_REG_W 3

// general registers, r0 to r7
`define DEC_NUM_REGS 8

// r7 is the program counter
`define DEC_PC_REG 7

// r5 is not special here, the flag write has its own strobe

`endif

/* decoder_pkg.sv */
`include "decoder_cfg.svh"

package decoder_pkg;

    // execution states, upper four bits 0111 form the nop group
    typedef enum logic [`DEC_OP_W-1:0] {
        op_hlt = 6'b000000, op_clr = 6'b000100,
        op_asl = 6'b001000, op_asr = 6'b001001, op_rlc = 6'b001010, op_rrc = 6'b001011,
        op_lsl = 6'b001100, op_lsr = 6'b001101, op_rol = 6'b001110, op_ror = 6'b001111,
        op_mov = 6'b010000, op_jmp = 6'b010001, op_ret = 6'b010010, op_rit = 6'b010011,
        op_add = 6'b010100, op_rjp = 6'b010101, op_adc = 6'b010110,
        op_sub = 6'b011000, op_sbc = 6'b011010, op_cmp = 6'b011011,
        op_nop = 6'b011100,
        op_or  = 6'b100000, op_xor = 6'b100001, op_and = 6'b100010, op_bit = 6'b100011,
        op_jsr = 6'b101100, op_rjs = 6'b101101, op_svc = 6'b101110,
        op_brn = 6'b110000, op_brz = 6'b110001, op_brv = 6'b110010, op_brc = 6'b110011,
        op_rbn = 6'b111000, op_rbz = 6'b111001, op_rbv = 6'b111010, op_rbc = 6'b111011
    } op_e;

    typedef enum logic [`DEC_MODE_W-1:0] {
        mode_d  = 2'b00,
        mode_i  = 2'b01,
        mode_mi = 2'b10,
        mode_ip = 2'b11
    } addr_mode_e;

    typedef struct packed {
        op_e                     op;
        addr_mode_e              f_mode;
        logic [`DEC_REG_W-1:0]   f_reg;
        addr_mode_e              t_mode;
        logic [`DEC_REG_W-1:0]   t_reg;
    } isr_t;

    typedef struct packed {
        logic if0, if1, ff0, ff1, ff2, tf0, tf1, ex1;
    } phase_t;

    typedef struct packed {
        logic n, z, v, c;
    } psw_t;

    typedef struct packed {
        op_e                            op;
        logic [`DEC_NUM_REGS-1:0]       f_reg_oh;
        logic [`DEC_NUM_REGS-1:0]       t_reg_oh;
        logic [(1 << `DEC_MODE_W)-1:0]  f_mode_oh;
        logic [(1 << `DEC_MODE_W)-1:0]  t_mode_oh;
        logic is_valid;
        logic is_result;
        logic is_shift;
        logic is_alu2;
        logic is_logic;
        logic is_branch;
        logic is_rbranch;
        logic is_call;
        logic is_flagset;
    } isr_dec_t;

    typedef struct packed {
        logic [`DEC_NUM_REGS-1:0] r_sel;
        logic [`DEC_NUM_REGS-1:0] w_sel;
        logic                     psw_wr;
    } reg_ctl_t;

    typedef struct packed {
        logic als, x, y, z, u, v, mda, b0b, sb0;
    } alu_ctl_t;

    typedef struct packed {
        logic shs, a, b, c, d, e, r, l;
    } shift_ctl_t;

    typedef struct packed {
        logic r_w_n, mreq_n, mirq_n, mis, mmd, smd, sma, mdm;
    } bus_ctl_t;

endpackage

/* decoder_tb.sv */
module decoder_tb
    import decoder_pkg::*;
();

    typedef struct packed {
        logic [3:0]  beh;
        logic [15:0] isr;
        logic [15:0] isr_rmask;
        phase_t      phase;
        psw_t        psw;
        logic [3:0]  psw_rmask;
        reg_ctl_t    reg_exp;
        reg_ctl_t    reg_mask;
        alu_ctl_t    alu_exp;
        alu_ctl_t    alu_mask;
        shift_ctl_t  sh_exp;
        shift_ctl_t  sh_mask;
        bus_ctl_t    bus_exp;
        bus_ctl_t    bus_mask;
    } entry_t;

    // not a defined opcode, so no opcode term fires
    localparam logic [5:0] op_none = 6'b000001;

    logic       clk;
    logic       reset;
    isr_t       isr;
    phase_t     phase;
    psw_t       psw;
    reg_ctl_t   dut_reg;
    alu_ctl_t   dut_alu;
    shift_ctl_t dut_shift;
    bus_ctl_t   dut_bus;

    entry_t      table_q[$];
    logic [31:0] lfsr_state = 32'hfcaec042;
    int          checks = 0;
    int          errors = 0;

    tb_clock_gen u_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    microcode_decoder u_microcode_decoder (
        .clk     (clk),
        .reset   (reset),
        .isr     (isr),
        .phase   (phase),
        .psw     (psw),
        .reg_ctl (dut_reg),
        .alu     (dut_alu),
        .shift   (dut_shift),
        .bus     (dut_bus)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function logic next_rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function logic [15:0] fill_random(input logic [15:0] base, input logic [15:0] mask);
        logic [15:0] v;
        v = base;
        for (int i = 0; i < 16; i++) begin
            if (mask[i])
                v[i] = next_rand_bit();
        end
        return v;
    endfunction

    function logic [15:0] make_isr(input logic [5:0] op, input logic [1:0] fm,
                                   input logic [2:0] fr, input logic [1:0] tm,
                                   input logic [2:0] tr);
        return {op, fm, fr, tm, tr};
    endfunction

    function entry_t blank(input logic [3:0] beh, input logic [15:0] bits,
                           input logic [15:0] rmask);
        entry_t b;
        b = '0;
        b.beh = beh;
        b.isr = bits;
        b.isr_rmask = rmask;
        return b;
    endfunction

    task check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: time %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic build_table();
        entry_t     e;
        logic [7:0] oh;
        logic [2:0] tr;
        logic [1:0] pos;
        logic [5:0] exec_ops [11] = '{op_add, op_or, op_clr, op_asl, op_asr, op_rlc,
                                      op_rrc, op_lsl, op_lsr, op_rol, op_ror};
        logic [5:0] br_ops [8] = '{op_brn, op_brz, op_brv, op_brc,
                                   op_rbn, op_rbz, op_rbv, op_rbc};
        logic [5:0] call_ops [3] = '{op_jsr, op_rjs, op_svc};
        logic [5:0] carry_ops [4] = '{op_adc, op_sbc, op_sub, op_cmp};

        // fetch
        e = blank(2, make_isr(op_none, 0, 0, 0, 0), 16'h03ff);
        e.psw_rmask = 4'hf;
        e.phase.if0 = 1'b1;
        e.reg_mask = '1;
        e.reg_exp.r_sel = 8'h80;
        e.bus_mask = '{mis: 1'b1, mmd: 1'b1, sma: 1'b1, default: 1'b0};
        e.bus_exp.sma = 1'b1;
        table_q.push_back(e);
        e.phase = '0;
        e.phase.if1 = 1'b1;
        e.reg_exp.w_sel = 8'h80;
        e.bus_exp = '{mis: 1'b1, mmd: 1'b1, default: 1'b0};
        e.alu_mask.u = 1'b1;
        e.alu_exp.u = 1'b1;
        table_q.push_back(e);

        // operand phases over all register numbers
        for (int i = 0; i < 8; i++) begin
            oh = 8'b1 << i;
            for (int v = 0; v < 5; v++) begin
                case (v)
                    0: e = blank(3, make_isr(op_none, 0, 3'(i), 0, 0), 16'h031f);
                    1: e = blank(3, make_isr(op_none, mode_ip, 3'(i), 0, 0), 16'h001f);
                    2: e = blank(3, make_isr(op_none, mode_d, 3'(i), 0, 0), 16'h001f);
                    3: e = blank(3, make_isr(op_none, 0, 0, mode_ip, 3'(i)), 16'h03e0);
                    default: e = blank(3, make_isr(op_none, 0, 0, mode_i, 3'(i)), 16'h03e0);
                endcase
                e.psw_rmask = 4'hf;
                e.phase.ff0 = (v == 0);
                e.phase.ff1 = (v == 1) || (v == 2);
                e.phase.tf1 = (v >= 3);
                e.reg_mask = '1;
                e.reg_exp.r_sel = (v == 0 || v == 1 || v == 3) ? oh : 8'h00;
                e.reg_exp.w_sel = e.reg_exp.r_sel;
                e.alu_mask.u = 1'b1;
                e.alu_exp.u = (v != 0);
                e.bus_mask = '{mis: 1'b1, mmd: 1'b1, sma: 1'b1, default: 1'b0};
                e.bus_exp.mmd = (v >= 3);
                e.bus_exp.sma = (v == 0);
                table_q.push_back(e);
            end
        end

        // execute writes, direct then indirect destination
        for (int k = 0; k < 11; k++) begin
            tr = 3'(k);
            for (int ind = 0; ind < 2; ind++) begin
                e = blank(4, make_isr(exec_ops[k], 0, 0, ind ? mode_i : mode_d, tr),
                          16'h03e0);
                e.psw_rmask = 4'hf;
                e.reg_mask = '1;
                e.reg_exp.w_sel = ind ? 8'h00 : (8'b1 << tr);
                e.reg_exp.psw_wr = 1'b1;
                e.sh_mask = '{shs: 1'b1, r: 1'b1, l: 1'b1, default: 1'b0};
                e.sh_exp.shs = (k >= 3);
                e.sh_exp.r = exec_ops[k] inside {op_asr, op_ror, op_rrc};
                e.sh_exp.l = exec_ops[k] inside {op_asl, op_lsl, op_rol, op_rlc};
                table_q.push_back(e);
            end
        end

        // branches, matching flag alone set or alone clear
        for (int k = 0; k < 8; k++) begin
            pos = 2'd3 - br_ops[k][1:0];
            for (int set = 0; set < 2; set++) begin
                e = blank(5, make_isr(br_ops[k], 0, 0, 0, 0), 16'h03ff);
                e.psw = set ? psw_t'(4'b1 << pos) : psw_t'(~(4'b1 << pos));
                e.reg_mask = '1;
                e.reg_exp.w_sel = set ? 8'h80 : 8'h00;
                table_q.push_back(e);
            end
        end
        for (int k = 0; k < 3; k++) begin
            for (int ex = 0; ex < 2; ex++) begin
                e = blank(5, make_isr(call_ops[k], 0, 0, 0, 0), 16'h03ff);
                e.psw_rmask = 4'hf;
                e.phase.ex1 = ex[0];
                e.reg_mask = '1;
                e.reg_exp.w_sel = ex ? 8'h80 : 8'h00;
                e.reg_exp.r_sel = (ex && call_ops[k] == op_rjs) ? 8'h80 : 8'h00;
                // decoded opcode always requests memory
                e.bus_mask = '{mreq_n: 1'b1, mdm: 1'b1, default: 1'b0};
                e.bus_exp.mdm = ex[0];
                table_q.push_back(e);
            end
        end

        // carry in
        for (int k = 0; k < 4; k++) begin
            for (int c = 0; c < 2; c++) begin
                e = blank(6, make_isr(carry_ops[k], 0, 0, 0, 0), 16'h03ff);
                e.psw.c = c[0];
                e.psw_rmask = 4'b1110;
                e.alu_mask.u = 1'b1;
                e.alu_mask.x = 1'b1;
                e.alu_exp.x = (carry_ops[k] != op_adc);
                if (carry_ops[k] == op_adc)
                    e.alu_exp.u = c[0];
                else if (carry_ops[k] == op_sbc)
                    e.alu_exp.u = !c[0];
                else
                    e.alu_exp.u = 1'b1;
                table_q.push_back(e);
            end
        end
    endtask

    initial begin
        #100000;
        $display("timeout: simulation ran past its time limit");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        entry_t      e;
        logic [15:0] pbits;
        int          wait_cycles;
        int          beh_checks;
        int          beh_errors;

        isr = isr_t'(make_isr(op_none, 0, 0, 0, 0));
        phase = '0;
        psw = '0;
        build_table();

        repeat (3) @(posedge clk);
        #1;
        check_value(32'(dut_reg), 32'h0, "reset reg_ctl");
        check_value(32'(dut_alu), 32'h0, "reset alu");
        check_value(32'(dut_shift), 32'h0, "reset shift");
        check_value(32'(dut_bus), 32'h60, "reset bus");
        $display("behavior 1: %0d checks, %0d errors", checks, errors);

        wait_cycles = 0;
        while (reset && wait_cycles < 50) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (reset) begin
            $display("timeout: reset was never released");
            $display("TEST RESULT: FAIL");
            $finish;
        end

        beh_checks = checks;
        beh_errors = errors;
        foreach (table_q[idx]) begin
            e = table_q[idx];
            @(posedge clk);
            #1;
            isr = isr_t'(fill_random(e.isr & ~e.isr_rmask, e.isr_rmask));
            phase = e.phase;
            pbits = fill_random({12'h0, e.psw & ~e.psw_rmask}, {12'h0, e.psw_rmask});
            psw = psw_t'(pbits[3:0]);
            @(posedge clk);
            #1;
            check_value(32'(dut_reg & e.reg_mask), 32'(e.reg_exp & e.reg_mask),
                        $sformatf("entry %0d reg_ctl", idx));
            check_value(32'(dut_alu & e.alu_mask), 32'(e.alu_exp & e.alu_mask),
                        $sformatf("entry %0d alu", idx));
            check_value(32'(dut_shift & e.sh_mask), 32'(e.sh_exp & e.sh_mask),
                        $sformatf("entry %0d shift", idx));
            check_value(32'(dut_bus & e.bus_mask), 32'(e.bus_exp & e.bus_mask),
                        $sformatf("entry %0d bus", idx));
            if (idx == table_q.size() - 1 || table_q[idx + 1].beh != e.beh) begin
                $display("behavior %0d: %0d checks, %0d errors", e.beh,
                         checks - beh_checks, errors - beh_errors);
                beh_checks = checks;
                beh_errors = errors;
            end
        end

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* isr_field_decode.sv */
`include "decoder_cfg.svh"

module isr_field_decode
    import decoder_pkg::*;
(
    input  isr_t     isr,
    output isr_dec_t dec
);

    logic [`DEC_ISR_W-1:0] isr_bits;
    logic                  nop_group;

    assign isr_bits = isr;

    // any code with upper opcode bits 0111 behaves as nop
    assign nop_group = (isr_bits[`DEC_ISR_W-1 -: 4] == 4'b0111);

    always_comb begin
        dec = '0;

        dec.op = nop_group ? op_nop : isr.op;

        // register numbers and modes to one-hot
        dec.f_reg_oh[isr.f_reg]   = 1'b1;
        dec.t_reg_oh[isr.t_reg]   = 1'b1;
        dec.f_mode_oh[isr.f_mode] = 1'b1;
        dec.t_mode_oh[isr.t_mode] = 1'b1;

        case (isr.op)
            op_hlt, op_clr,
            op_asl, op_asr, op_rlc, op_rrc, op_lsl, op_lsr, op_rol, op_ror,
            op_mov, op_jmp, op_ret, op_rit,
            op_add, op_rjp, op_adc, op_sub, op_sbc, op_cmp,
            op_or, op_xor, op_and, op_bit,
            op_jsr, op_rjs, op_svc,
            op_brn, op_brz, op_brv, op_brc,
            op_rbn, op_rbz, op_rbv, op_rbc: dec.is_valid = 1'b1;
            default:                        dec.is_valid = nop_group;
        endcase

        dec.is_shift = dec.op inside {op_asl, op_asr, op_rlc, op_rrc,
                                      op_lsl, op_lsr, op_rol, op_ror};
        dec.is_alu2 = dec.op inside {op_add, op_adc, op_sub, op_sbc, op_cmp, op_rjp};
        dec.is_logic = dec.op inside {op_or, op_xor, op_and, op_bit};
        dec.is_branch = dec.op inside {op_brn, op_brz, op_brv, op_brc};
        dec.is_rbranch = dec.op inside {op_rbn, op_rbz, op_rbv, op_rbc};
        dec.is_call = dec.op inside {op_jsr, op_rjs, op_svc};

        // opcodes that write a result to the destination register
        dec.is_result = (dec.op == op_clr) | (dec.op == op_mov) | dec.is_shift |
                        (dec.is_alu2 & (dec.op != op_cmp)) |
                        (dec.is_logic & (dec.op != op_bit));

        // opcodes that update n, z, v, c (rjp does not)
        dec.is_flagset = (dec.op == op_clr) | (dec.op == op_mov) | dec.is_shift |
                         (dec.is_alu2 & (dec.op != op_rjp)) | dec.is_logic;
    end

endmodule

/* microcode_decoder.sv */
`include "decoder_cfg.svh"

module microcode_decoder
    import decoder_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  isr_t       isr,
    input  phase_t     phase,
    input  psw_t       psw,
    output reg_ctl_t   reg_ctl,
    output alu_ctl_t   alu,
    output shift_ctl_t shift,
    output bus_ctl_t   bus
);

    // no memory request while idle
    localparam bus_ctl_t bus_idle = '{mreq_n: 1'b1, mirq_n: 1'b1, default: 1'b0};

    isr_dec_t   dec;
    reg_ctl_t   reg_ctl_d;
    alu_ctl_t   alu_d;
    shift_ctl_t shift_d;
    bus_ctl_t   bus_d;

    isr_field_decode u_isr_field_decode (
        .isr (isr),
        .dec (dec)
    );

    reg_select_decode u_reg_select_decode (
        .dec     (dec),
        .phase   (phase),
        .psw     (psw),
        .reg_ctl (reg_ctl_d)
    );

    alu_shift_control u_alu_shift_control (
        .dec   (dec),
        .phase (phase),
        .psw   (psw),
        .alu   (alu_d),
        .shift (shift_d)
    );

    bus_control u_bus_control (
        .dec   (dec),
        .phase (phase),
        .bus   (bus_d)
    );

    // one register stage for glitch-free strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_ctl <= '0;
            alu     <= '0;
            shift   <= '0;
            bus     <= bus_idle;
        end else begin
            reg_ctl <= reg_ctl_d;
            alu     <= alu_d;
            shift   <= shift_d;
            bus     <= bus_d;
        end
    end

endmodule

/* reg_select_decode.sv */
`include "decoder_cfg.svh"

module reg_select_decode
    import decoder_pkg::*;
(
    input  isr_dec_t dec,
    input  phase_t   phase,
    input  psw_t     psw,
    output reg_ctl_t reg_ctl
);

    logic f_ip;
    logic t_ip;
    logic t_d;
    logic br_flag;
    logic br_taken;
    logic pc_rd;
    logic pc_wr;

    assign f_ip = dec.f_mode_oh[mode_ip];
    assign t_ip = dec.t_mode_oh[mode_ip];
    assign t_d  = dec.t_mode_oh[mode_d];

    // low two opcode bits pick the tested flag for both branch groups
    always_comb begin
        case (dec.op[1:0])
            2'b00:   br_flag = psw.n;
            2'b01:   br_flag = psw.z;
            2'b10:   br_flag = psw.v;
            default: br_flag = psw.c;
        endcase
    end

    assign br_taken = (dec.is_branch | dec.is_rbranch) & br_flag;

    assign pc_rd = phase.if0 | phase.if1 | ((dec.op == op_rjs) & phase.ex1);

    assign pc_wr = phase.if1 |
                   (dec.op == op_jmp) | (dec.op == op_ret) | (dec.op == op_rit) |
                   br_taken |
                   (dec.is_call & phase.ex1);

    always_comb begin
        // operand fetch and autoincrement reads
        reg_ctl.r_sel = ({`DEC_NUM_REGS{phase.ff0}}        & dec.f_reg_oh) |
                        ({`DEC_NUM_REGS{phase.ff1 & f_ip}} & dec.f_reg_oh) |
                        ({`DEC_NUM_REGS{phase.tf0}}        & dec.t_reg_oh) |
                        ({`DEC_NUM_REGS{phase.tf1 & t_ip}} & dec.t_reg_oh);

        // autoincrement writeback and direct-mode results
        reg_ctl.w_sel = ({`DEC_NUM_REGS{phase.ff0}}           & dec.f_reg_oh) |
                        ({`DEC_NUM_REGS{phase.ff1 & f_ip}}    & dec.f_reg_oh) |
                        ({`DEC_NUM_REGS{phase.tf1 & t_ip}}    & dec.t_reg_oh) |
                        ({`DEC_NUM_REGS{dec.is_result & t_d}} & dec.t_reg_oh);

        reg_ctl.r_sel[`DEC_PC_REG] = reg_ctl.r_sel[`DEC_PC_REG] | pc_rd;
        reg_ctl.w_sel[`DEC_PC_REG] = reg_ctl.w_sel[`DEC_PC_REG] | pc_wr;

        reg_ctl.psw_wr = dec.is_flagset;
    end

endmodule

/* sources.f */
+incdir+.
decoder_pkg.sv
isr_field_decode.sv
reg_select_decode.sv
alu_shift_control.sv
bus_control.sv
microcode_decoder.sv
tb_clock_gen.sv
decoder_assert.sv
decoder_tb.sv

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for eight rising edges
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule
